//--- bench/rv_mem_model.sv
// Word-wide memory model for the core bus, with 0 to 3 random wait cycles
// Every completed write is logged in order for the testbench to check

`timescale 1ns/100ps

module rv_mem_model (
   input  logic             clk,
   input  logic             mem_valid,
   input  rv_pkg::mem_req_t mem_req,
   output logic             mem_ready,
   output rv_pkg::word_t    mem_rdata
);
   import rv_pkg::*;

   localparam int MEM_WORDS = 256;
   localparam int LOG_DEPTH = 64;

   word_t  mem [0:MEM_WORDS-1];
   word_t  log_addr [0:LOG_DEPTH-1];
   word_t  log_data [0:LOG_DEPTH-1];
   integer write_count;
   integer seed;
   integer wait_left;
   logic   pending;

   initial begin
      seed = 32'h73b4;
      write_count = 0;
      wait_left = 0;
      pending = 1'b0;
      mem_ready = 1'b0;
      mem_rdata = '0;
      // Fill that differs for every byte address
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = 32'hbad0_0000 ^ (i << 2);
      end
   end

   task automatic load_word(input integer index, input word_t data);
      mem[index] = data;
   endtask

   // Answers 1 ns after the edge, once the request of this cycle is stable
   always @(posedge clk) begin
      #1;
      mem_ready = 1'b0;
      if (mem_valid) begin
         // New request, draw its wait states
         if (!pending) begin
            wait_left = $unsigned($random(seed)) % 4;
            pending = 1'b1;
         end
         if (wait_left == 0) begin
            mem_ready = 1'b1;
            pending = 1'b0;
            mem_rdata = mem[mem_req.addr[9:2]];
            if (mem_req.write) begin
               mem[mem_req.addr[9:2]] = mem_req.wdata;
               if (write_count < LOG_DEPTH) begin
                  log_addr[write_count] = mem_req.addr;
                  log_data[write_count] = mem_req.wdata;
               end
               write_count = write_count + 1;
            end
         end else begin
            wait_left = wait_left - 1;
         end
      end
   end

endmodule

//--- bench/rv_patterns.mem
// Word 0 is the program length N, then N instruction words from address 0,
// then the write count M and M lines of expected write address and data
0000002D
20000093 12345137 67810113 0F0F11B7   // base in x1, operands in x2 and x3
0F018193 00310233 0040A023            // ADD and store
403102B3 0050A223 00317333 0060A423   // SUB and AND
003163B3 0070A623 00314433 0080A823   // OR and XOR
FFF10493 0090AA23 FFF14513 00A0AC23   // ADDI and XORI with -1
F0017593 00B0AE23 8001E613 02C0A023   // ANDI -256 and ORI -2048
00510013 0200A223                     // write to x0 then store x0
0000A683 00168693 02D0A423            // load back the first store, add 1
00310463 0220A623 00311463 0230A623   // BEQ not taken, BNE taken
00948463 0230A623 00421463 0250A823   // BEQ taken, BNE not taken
00C0076F 0230AA23 0230AA23 02E0AA23   // JAL over two stores, store link
00200793 FFF78793 02F0AC23 FE079CE3   // countdown loop, backward BNE
0000006F                              // park in a self loop
00000010
00000200 21436768
00000204 03254588
00000208 02041070
0000020C 1F3F56F8
00000210 1D3B4688
00000214 12345677
00000218 EDCBA987
0000021C 12345600
00000220 FFFFF8F0
00000224 00000000
00000228 21436769
0000022C 12345678
00000230 03254588
00000234 00000094
00000238 00000001
00000238 00000000

//--- bench/rv_tb.sv
// Testbench for the RV32I subset core on its shared memory bus
// Loads program and expected writes from the pattern file, then checks
// every write that reaches memory, in order

`timescale 1ns/100ps

module rv_tb;
   import rv_pkg::*;

   localparam int PAT_WORDS = 256;
   localparam int WRITE_TIMEOUT = 300;
   localparam int SETTLE_CYCLES = 40;

   logic     clk;
   logic     rst_n;
   logic     mem_valid;
   mem_req_t mem_req;
   logic     mem_ready;
   word_t    mem_rdata;

   word_t    pat [0:PAT_WORDS-1];
   integer   num_inst;
   integer   num_writes;
   integer   exp_base;
   integer   mismatch_count;
   integer   failure_count;
   logic     write_seen;

   rv_cpu dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata)
   );

   rv_mem_model u_mem (
      .clk       (clk),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .mem_ready (mem_ready),
      .mem_rdata (mem_rdata)
   );

   always #4 clk = ~clk;

   // ============================================================
   // Checking helpers
   // ============================================================
   task automatic compare_value(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         mismatch_count = mismatch_count + 1;
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   // Polls the write log once per clock until entry index exists
   task automatic wait_for_write(input integer index, output logic seen);
      integer cycles;
      seen = 1'b0;
      cycles = 0;
      while (!seen && cycles < WRITE_TIMEOUT) begin
         if (u_mem.write_count > index) begin
            seen = 1'b1;
         end else begin
            @(posedge clk);
            cycles = cycles + 1;
         end
      end
   endtask

   // ============================================================
   // Stimulus and checking
   // ============================================================
   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      mismatch_count = 0;
      failure_count = 0;
      write_seen = 1'b1;
      num_inst = 0;
      num_writes = 0;
      exp_base = 0;
      for (int i = 0; i < PAT_WORDS; i++) begin
         pat[i] = '0;
      end
      $readmemh("bench/rv_patterns.mem", pat);

      repeat (5) @(posedge clk);
      // Program goes in while the core is still held in reset
      num_inst = pat[0];
      if (num_inst <= 0 || num_inst > PAT_WORDS - 2) begin
         $display("pattern file holds no usable program");
         failure_count = failure_count + 1;
      end else begin
         for (int i = 0; i < num_inst; i++) begin
            u_mem.load_word(i, pat[1 + i]);
         end
         num_writes = pat[num_inst + 1];
         exp_base = num_inst + 2;
      end
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < num_writes && write_seen; i++) begin
         wait_for_write(i, write_seen);
         if (write_seen) begin
            compare_value($sformatf("write %0d address", i), pat[exp_base + 2 * i],
                          u_mem.log_addr[i]);
            compare_value($sformatf("write %0d data", i), pat[exp_base + 2 * i + 1],
                          u_mem.log_data[i]);
         end else begin
            $display("timeout while waiting for write %0d of %0d", i, num_writes);
            failure_count = failure_count + 1;
         end
      end

      // Core parks in a self loop, so no further writes may appear
      if (write_seen) begin
         repeat (SETTLE_CYCLES) @(posedge clk);
         compare_value("write count", num_writes, u_mem.write_count);
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- compile.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_fetch.sv
verilog/rv_lsu.sv
verilog/rv_mem_arbiter.sv
verilog/rv_cpu.sv
bench/rv_mem_model.sv
bench/rv_tb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module rv_tb -o rv_tb_sim

out=$(./obj_dir/rv_tb_sim)
echo "$out"
echo "$out" | grep -q "TEST PASSED"

//--- verilog/rv_alu.sv
// Integer ALU for the kept operations
// The zero flag drives the BEQ/BNE decision in the top level

`timescale 1ns/100ps

module rv_alu (
   input  rv_pkg::alu_op_e op,
   input  rv_pkg::word_t   a,
   input  rv_pkg::word_t   b,
   output rv_pkg::word_t   result,
   output logic            zero
);
   import rv_pkg::*;

   always_comb begin
      case (op)
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         // PASS_B, used by LUI
         default: result = b;
      endcase
   end

   assign zero = (result == '0);

endmodule

//--- verilog/rv_cpu.sv
// Top of the multicycle RV32I subset core on one shared memory bus
// Issue, branch resolution and writeback live here

`timescale 1ns/100ps

module rv_cpu (
   input  logic             clk,
   input  logic             rst_n,
   output logic             mem_valid,
   output rv_pkg::mem_req_t mem_req,
   input  logic             mem_ready,
   input  rv_pkg::word_t    mem_rdata
);
   import rv_pkg::*;

   logic     inst_valid;
   word_t    inst;
   word_t    inst_pc;
   logic     consume;
   logic     redirect;
   word_t    redirect_pc;
   ctrl_t    ctrl;
   word_t    rdata1;
   word_t    rdata2;
   word_t    alu_b;
   word_t    alu_result;
   logic     alu_zero;
   logic     branch_taken;
   logic     lsu_start;
   logic     lsu_busy;
   logic     load_done;
   word_t    load_data;
   reg_idx_t load_rd;
   logic     rf_we;
   reg_idx_t rf_rd;
   word_t    rf_wdata;
   word_t    link;
   logic     fetch_bus_valid;
   mem_req_t fetch_bus_req;
   logic     fetch_bus_ready;
   logic     lsu_bus_valid;
   mem_req_t lsu_bus_req;
   logic     lsu_bus_ready;
   word_t    bus_rdata;

   // ============================================================
   // Issue and branch
   // ============================================================
   assign consume = inst_valid && !lsu_busy && !load_done;
   assign lsu_start = consume && (ctrl.mem_read || ctrl.mem_write);

   assign branch_taken = (ctrl.branch == BR_EQ && alu_zero) ||
                         (ctrl.branch == BR_NE && !alu_zero);
   assign redirect = consume && (ctrl.jump || branch_taken);
   assign redirect_pc = inst_pc + ctrl.imm;
   assign link = inst_pc + 32'd4;

   assign alu_b = ctrl.use_imm ? ctrl.imm : rdata2;

   // Destination of the load in flight
   always_ff @(posedge clk) begin
      if (lsu_start) load_rd <= ctrl.rd;
   end

   // ============================================================
   // Writeback
   // ============================================================
   assign rf_we = load_done || (consume && ctrl.reg_write && !ctrl.mem_read);
   assign rf_rd = load_done ? load_rd : ctrl.rd;
   assign rf_wdata = load_done ? load_data : (ctrl.jump ? link : alu_result);

   rv_decoder u_decoder (
      .inst (inst),
      .ctrl (ctrl)
   );

   rv_regfile u_regfile (
      .clk    (clk),
      .rst_n  (rst_n),
      .rs1    (ctrl.rs1),
      .rs2    (ctrl.rs2),
      .rd     (rf_rd),
      .wdata  (rf_wdata),
      .we     (rf_we),
      .rdata1 (rdata1),
      .rdata2 (rdata2)
   );

   rv_alu u_alu (
      .op     (ctrl.alu_op),
      .a      (rdata1),
      .b      (alu_b),
      .result (alu_result),
      .zero   (alu_zero)
   );

   rv_fetch u_fetch (
      .clk         (clk),
      .rst_n       (rst_n),
      .inst_valid  (inst_valid),
      .inst        (inst),
      .inst_pc     (inst_pc),
      .consume     (consume),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .bus_valid   (fetch_bus_valid),
      .bus_req     (fetch_bus_req),
      .bus_ready   (fetch_bus_ready),
      .bus_rdata   (bus_rdata)
   );

   rv_lsu u_lsu (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (lsu_start),
      .addr      (alu_result),
      .wdata     (rdata2),
      .write     (ctrl.mem_write),
      .busy      (lsu_busy),
      .load_done (load_done),
      .load_data (load_data),
      .bus_valid (lsu_bus_valid),
      .bus_req   (lsu_bus_req),
      .bus_ready (lsu_bus_ready),
      .bus_rdata (bus_rdata)
   );

   rv_mem_arbiter u_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .lsu_valid   (lsu_bus_valid),
      .lsu_req     (lsu_bus_req),
      .lsu_ready   (lsu_bus_ready),
      .fetch_valid (fetch_bus_valid),
      .fetch_req   (fetch_bus_req),
      .fetch_ready (fetch_bus_ready),
      .rdata       (bus_rdata),
      .mem_valid   (mem_valid),
      .mem_req     (mem_req),
      .mem_ready   (mem_ready),
      .mem_rdata   (mem_rdata)
   );

endmodule

//--- verilog/rv_decoder.sv
// Instruction decoder for the kept RV32I subset
// Pure combinational, produces the control bundle used at issue

`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_decoder (
   input  rv_pkg::word_t inst,
   output rv_pkg::ctrl_t ctrl
);
   import rv_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;

   assign opcode = inst[6:0];
   assign funct3 = inst[14:12];
   assign funct7 = inst[31:25];

   // Immediate rebuild, sign bit is always inst[31]
   assign imm_i = {{20{inst[31]}}, inst[31:20]};
   assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign imm_u = {inst[31:12], 12'b0};
   assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   always_comb begin
      ctrl = '0;
      ctrl.rd = inst[11:7];
      ctrl.rs1 = inst[19:15];
      ctrl.rs2 = inst[24:20];
      case (opcode)
         `RV_OP_LUI: begin
            ctrl.alu_op = ALU_PASS_B;
            ctrl.use_imm = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.imm = imm_u;
         end
         `RV_OP_JAL: begin
            ctrl.jump = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.imm = imm_j;
         end
         `RV_OP_BRANCH: begin
            // Compare by subtraction, zero flag decides
            ctrl.alu_op = ALU_SUB;
            ctrl.imm = imm_b;
            case (funct3)
               3'b000:  ctrl.branch = BR_EQ;
               3'b001:  ctrl.branch = BR_NE;
               default: ctrl.branch = BR_NONE;
            endcase
         end
         `RV_OP_LOAD: begin
            if (funct3 == 3'b010) begin
               ctrl.mem_read = 1'b1;
               ctrl.reg_write = 1'b1;
               ctrl.use_imm = 1'b1;
               ctrl.imm = imm_i;
            end
         end
         `RV_OP_STORE: begin
            if (funct3 == 3'b010) begin
               ctrl.mem_write = 1'b1;
               ctrl.use_imm = 1'b1;
               ctrl.imm = imm_s;
            end
         end
         `RV_OP_IMM: begin
            ctrl.use_imm = 1'b1;
            ctrl.reg_write = 1'b1;
            ctrl.imm = imm_i;
            case (funct3)
               3'b000:  ctrl.alu_op = ALU_ADD;
               3'b100:  ctrl.alu_op = ALU_XOR;
               3'b110:  ctrl.alu_op = ALU_OR;
               3'b111:  ctrl.alu_op = ALU_AND;
               default: ctrl.reg_write = 1'b0;
            endcase
         end
         `RV_OP_REG: begin
            ctrl.reg_write = 1'b1;
            case ({funct7, funct3})
               10'b0000000_000: ctrl.alu_op = ALU_ADD;
               10'b0100000_000: ctrl.alu_op = ALU_SUB;
               10'b0000000_100: ctrl.alu_op = ALU_XOR;
               10'b0000000_110: ctrl.alu_op = ALU_OR;
               10'b0000000_111: ctrl.alu_op = ALU_AND;
               default:         ctrl.reg_write = 1'b0;
            endcase
         end
         default: ;
      endcase
   end

endmodule

//--- verilog/rv_defines.svh
// Core-wide constants for the RV32I subset core
// Include in any file that needs widths, the reset PC or opcode values

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_RESET_PC  32'h0000_0000

// Major opcodes of the kept instructions
`define RV_OP_LUI    7'b0110111
`define RV_OP_JAL    7'b1101111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`endif

//--- verilog/rv_fetch.sv
// Instruction fetch with a one-entry buffer in front of the issue logic
// Requests go out one cycle after the buffer frees up; redirects load the PC

`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_fetch (
   input  logic             clk,
   input  logic             rst_n,
   output logic             inst_valid,
   output rv_pkg::word_t    inst,
   output rv_pkg::word_t    inst_pc,
   input  logic             consume,
   input  logic             redirect,
   input  rv_pkg::word_t    redirect_pc,
   output logic             bus_valid,
   output rv_pkg::mem_req_t bus_req,
   input  logic             bus_ready,
   input  rv_pkg::word_t    bus_rdata
);
   import rv_pkg::*;

   fetch_state_e state;
   word_t        pc;
   word_t        req_addr;
   logic         buf_valid;
   word_t        buf_inst;
   word_t        buf_pc;
   logic         done;
   logic         issue;
   logic         fill;

   assign done = bus_valid && bus_ready;
   // Only issue with nothing outstanding, so a fill never meets a full buffer
   assign issue = (state == FETCH_IDLE) && (!buf_valid || (consume && !redirect));
   assign fill = done && (state == FETCH_WAIT) && !redirect;

   assign bus_valid = (state != FETCH_IDLE);
   assign bus_req = '{addr: req_addr, wdata: '0, write: 1'b0};

   // ============================================================
   // Request FSM and PC
   // ============================================================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= FETCH_IDLE;
         pc <= `RV_RESET_PC;
         buf_valid <= 1'b0;
      end else begin
         case (state)
            FETCH_IDLE: if (issue) state <= FETCH_WAIT;
            FETCH_WAIT: begin
               if (done) state <= FETCH_IDLE;
               else if (redirect) state <= FETCH_DISCARD;
            end
            // Wrong-path word still on the bus, drop it when it lands
            FETCH_DISCARD: if (done) state <= FETCH_IDLE;
            default: state <= FETCH_IDLE;
         endcase

         if (redirect) pc <= redirect_pc;
         else if (issue) pc <= pc + 32'd4;

         if (fill) buf_valid <= 1'b1;
         else if (consume) buf_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) req_addr <= pc;
      if (fill) begin
         buf_inst <= bus_rdata;
         buf_pc <= req_addr;
      end
   end

   assign inst_valid = buf_valid;
   assign inst = buf_inst;
   assign inst_pc = buf_pc;

   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      bus_valid && !bus_ready |=> bus_valid && $stable(bus_req));

endmodule

//--- verilog/rv_lsu.sv
// Load/store unit, holds a single word access until the bus accepts it
// load_done pulses with the read data in the completion cycle of a load

`timescale 1ns/100ps

module rv_lsu (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             start,
   input  rv_pkg::word_t    addr,
   input  rv_pkg::word_t    wdata,
   input  logic             write,
   output logic             busy,
   output logic             load_done,
   output rv_pkg::word_t    load_data,
   output logic             bus_valid,
   output rv_pkg::mem_req_t bus_req,
   input  logic             bus_ready,
   input  rv_pkg::word_t    bus_rdata
);
   import rv_pkg::*;

   lsu_state_e state;
   mem_req_t   req;
   logic       done;

   assign done = bus_valid && bus_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= LSU_IDLE;
      end else begin
         case (state)
            LSU_IDLE: if (start) state <= LSU_BUSY;
            LSU_BUSY: if (done) state <= LSU_IDLE;
            default:  state <= LSU_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) req <= '{addr: addr, wdata: wdata, write: write};
   end

   assign bus_valid = (state == LSU_BUSY);
   assign bus_req = req;
   assign busy = bus_valid;
   assign load_done = done && !req.write;
   assign load_data = bus_rdata;

   // Issue logic in the top must hold off while an access is pending
   a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> !busy);

endmodule

//--- verilog/rv_mem_arbiter.sv
// Two-way arbiter for the shared memory bus
// The load/store unit wins a free bus
// A transfer that is waiting keeps its owner until ready

`timescale 1ns/100ps

module rv_mem_arbiter (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             lsu_valid,
   input  rv_pkg::mem_req_t lsu_req,
   output logic             lsu_ready,
   input  logic             fetch_valid,
   input  rv_pkg::mem_req_t fetch_req,
   output logic             fetch_ready,
   output rv_pkg::word_t    rdata,
   output logic             mem_valid,
   output rv_pkg::mem_req_t mem_req,
   input  logic             mem_ready,
   input  rv_pkg::word_t    mem_rdata
);
   import rv_pkg::*;

   logic locked;
   logic owner_lsu;
   logic grant_lsu;
   logic xfer;

   assign grant_lsu = locked ? owner_lsu : lsu_valid;

   assign mem_valid = grant_lsu ? lsu_valid : fetch_valid;
   assign mem_req = grant_lsu ? lsu_req : fetch_req;
   assign xfer = mem_valid && mem_ready;

   assign lsu_ready = xfer && grant_lsu;
   assign fetch_ready = xfer && !grant_lsu;
   assign rdata = mem_rdata;

   // Lock while a started request is still waiting
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         locked <= 1'b0;
         owner_lsu <= 1'b0;
      end else begin
         locked <= mem_valid && !mem_ready;
         owner_lsu <= grant_lsu;
      end
   end

   // Owner switch during a wait would change the request on the bus
   a_hold_owner: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_req));

endmodule

//--- verilog/rv_pkg.sv
// Shared types of the core: data words, control bundle, bus request
// and the state encodings of the fetch and load/store FSMs

`include "rv_defines.svh"

package rv_pkg;

   typedef logic [`RV_XLEN-1:0] word_t;
   typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef enum logic [1:0] {
      BR_NONE,
      BR_EQ,
      BR_NE
   } branch_e;

   // Decoded instruction, consumed in the issue cycle
   typedef struct packed {
      alu_op_e  alu_op;
      logic     use_imm;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      branch_e  branch;
      logic     jump;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      word_t    imm;
   } ctrl_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  write;
   } mem_req_t;

   typedef enum logic [1:0] {FETCH_IDLE, FETCH_WAIT, FETCH_DISCARD} fetch_state_e;
   typedef enum logic {LSU_IDLE, LSU_BUSY} lsu_state_e;

endpackage

//--- verilog/rv_regfile.sv
// Integer register file, two combinational reads and one clocked write
// x0 reads as zero and ignores writes

`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regfile (
   input  logic             clk,
   input  logic             rst_n,
   input  rv_pkg::reg_idx_t rs1,
   input  rv_pkg::reg_idx_t rs2,
   input  rv_pkg::reg_idx_t rd,
   input  rv_pkg::word_t    wdata,
   input  logic             we,
   output rv_pkg::word_t    rdata1,
   output rv_pkg::word_t    rdata2
);
   import rv_pkg::*;

   word_t regs [`RV_NUM_REGS];

   always_ff @(posedge clk) begin
      if (we && rd != '0) begin
         regs[rd] <= wdata;
      end
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

   // Writeback index comes from decode or the load tracking register
   a_we_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
      we |-> !$isunknown(rd));

endmodule
